// File: logic/bdd_settings.svh
`ifndef BDD_SETTINGS_SVH
`define BDD_SETTINGS_SVH

// Node and variable widths
`define BDD_INDEX_W 24
`define BDD_VAR_W 8
`define BDD_VAR_COUNT 32 // Deepest recursion the stacks must hold

`define REQ_STACK_DEPTH (3 * `BDD_VAR_COUNT)
`define RES_STACK_DEPTH (2 * `BDD_VAR_COUNT)

// Host config port, word addressed
`define CFG_ADDR_W 16
`define CFG_DATA_W 32
`define CFG_WORD_F 0
`define CFG_WORD_G 1
`define CFG_WORD_START 2
`define CFG_WORD_RESULT 6

// Terminal nodes
`define BDD_ZERO {`BDD_INDEX_W{1'b0}}
`define BDD_ONE {{(`BDD_INDEX_W - 1){1'b0}}, 1'b1}

`endif

// File: logic/bddPkg.sv
`include "bdd_settings.svh"

package bddPkg;

	typedef logic [`BDD_INDEX_W-1:0] bddIndexT;
	typedef logic [`BDD_VAR_W-1:0] bddVarT;

	typedef enum logic {
		applyState = 1'b0,
		reduceState = 1'b1
	} reqStateT;

	typedef struct packed {
		bddIndexT f;
		bddIndexT g;
		bddVarT top; // Variable of the node a Reduce builds
		reqStateT state;
	} bddRequestT;

	typedef enum logic {
		fetch = 1'b0,
		findOrInsert = 1'b1
	} agentChanT;

	// a and b hold f and g on a fetch and e and t on a find-or-insert
	typedef struct packed {
		agentChanT chan;
		bddIndexT a;
		bddIndexT b;
		bddVarT top;
	} agentRequestT;

	typedef struct packed {
		agentChanT chan;
		logic simpleHit;
		bddIndexT result;
		bddIndexT fn; // Then cofactor of f
		bddIndexT fnv; // Else cofactor of f
		bddIndexT gn;
		bddIndexT gnv;
		bddVarT top;
	} agentResultT;

endpackage

// File: logic/bddLifo.sv
`timescale 1ns/1ns

module bddLifo #(
	parameter type payloadT = logic [7:0],
	parameter int depth = 8
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic push,
	input payloadT pushData,
	input logic popOne,
	input logic popTwo,
	output payloadT top,
	output payloadT next,
	output logic empty
);

	localparam int ptrW = $clog2(depth + 1);

	payloadT mem [2**ptrW]; // Covers every pointer value, wrapped ones included

	logic [ptrW-1:0] index; // First free slot
	logic [ptrW-1:0] topPtr;
	logic [ptrW-1:0] nextPtr;
	logic [ptrW-1:0] indexNew;
	logic [ptrW-1:0] topPtrNew;
	logic [ptrW-1:0] nextPtrNew;

	always_comb
	begin
		indexNew = index;
		topPtrNew = topPtr;
		nextPtrNew = nextPtr;
		if (push)
		begin
			indexNew = index + 1'b1;
			topPtrNew = index;
			nextPtrNew = topPtr;
		end
		else if (popTwo)
		begin
			indexNew = nextPtr;
			topPtrNew = nextPtr - 1'b1;
			nextPtrNew = nextPtr - 2'd2;
		end
		else if (popOne)
		begin
			indexNew = topPtr;
			topPtrNew = nextPtr;
			nextPtrNew = nextPtr - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			index <= '0;
			topPtr <= '1; // Just below the bottom slot
			nextPtr <= {{(ptrW - 1){1'b1}}, 1'b0};
		end
		else
		begin
			index <= indexNew;
			topPtr <= topPtrNew;
			nextPtr <= nextPtrNew;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[index] <= pushData;
	end

	// Top two entries follow the new pointers, a pushed word goes straight to top
	always_ff @(posedge clk)
	begin
		top <= push ? pushData : mem[topPtrNew];
		next <= mem[nextPtrNew];
	end

	assign empty = (index == '0);

endmodule

// File: logic/requestSequencer.sv
`timescale 1ns/1ns

`include "bdd_settings.svh"

module requestSequencer
	import bddPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CFG_ADDR_W-1:0] cfgAddress,
	input logic cfgWrite,
	input logic [`CFG_DATA_W-1:0] cfgWriteData,
	input logic cfgRead,
	output logic [`CFG_DATA_W-1:0] cfgReadData,
	output logic cfgReadValid,
	output logic reqPush,
	output bddRequestT reqPushData,
	output logic reqPop,
	input bddRequestT reqTop,
	input logic reqEmpty,
	output logic resPush,
	output bddIndexT resPushData,
	input bddIndexT resTop,
	output logic fetchReq,
	output bddIndexT fetchF,
	output bddIndexT fetchG,
	input logic fetchDone,
	input agentResultT fetchResult,
	output logic reduceStart,
	output bddVarT reduceTop,
	input logic reduceDone,
	output logic clear
);

	localparam logic [`CFG_ADDR_W-1:0] wordF = `CFG_WORD_F;
	localparam logic [`CFG_ADDR_W-1:0] wordG = `CFG_WORD_G;
	localparam logic [`CFG_ADDR_W-1:0] wordStart = `CFG_WORD_START;
	localparam logic [`CFG_ADDR_W-1:0] wordResult = `CFG_WORD_RESULT;

	typedef enum logic [2:0] {
		seqIdle,
		seqDispatch, // Current request goes out
		seqWait, // Fetch or Reduce outstanding
		seqHit,
		seqThen,
		seqElse,
		seqFinish
	} seqStateT;

	seqStateT state;
	bddRequestT current;
	agentResultT answer; // Last fetch response
	bddIndexT finalResult;
	logic finished;
	logic busy;
	logic hostWrite;
	logic startWrite;
	logic advance;

	assign busy = (state != seqIdle);
	assign hostWrite = cfgWrite && !busy;
	assign startWrite = hostWrite && (cfgAddress == wordStart);

	// A result is on its way to the stack so the next request can come up
	assign advance = (state == seqHit) || (state == seqWait && reduceDone);
	assign reqPop = advance && !reqEmpty;

	// Then-apply is issued while the Else-apply is being pushed
	assign fetchReq = (state == seqDispatch || state == seqElse) && current.state == applyState;
	assign reduceStart = (state == seqDispatch) && current.state == reduceState;
	assign fetchF = current.f;
	assign fetchG = current.g;
	assign reduceTop = current.top;
	assign resPush = (state == seqHit);
	assign resPushData = answer.result;
	assign reqPush = (state == seqThen) || (state == seqElse);
	assign clear = (state == seqFinish);

	always_comb
	begin
		reqPushData.f = answer.fnv;
		reqPushData.g = answer.gnv;
		reqPushData.top = '0;
		reqPushData.state = applyState;
		if (state == seqThen)
		begin
			// Reduce sits below the Else-apply until both halves are back
			reqPushData.f = '0;
			reqPushData.g = '0;
			reqPushData.top = answer.top;
			reqPushData.state = reduceState;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= seqIdle;
		else
		begin
			case (state)
				seqIdle:
				begin
					if (startWrite)
						state <= seqDispatch;
				end
				seqDispatch: state <= seqWait;
				seqWait:
				begin
					if (fetchDone)
						state <= fetchResult.simpleHit ? seqHit : seqThen;
					else if (reduceDone)
						state <= reqEmpty ? seqFinish : seqDispatch;
				end
				seqHit: state <= reqEmpty ? seqFinish : seqDispatch;
				seqThen: state <= seqElse;
				seqElse: state <= seqWait;
				seqFinish: state <= seqIdle;
				default: state <= seqIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (hostWrite && cfgAddress == wordF)
			current.f <= cfgWriteData[`BDD_INDEX_W-1:0];
		if (hostWrite && cfgAddress == wordG)
			current.g <= cfgWriteData[`BDD_INDEX_W-1:0];
		if (startWrite)
		begin
			current.top <= '0;
			current.state <= applyState;
		end
		if (state == seqThen)
		begin
			current.f <= answer.fn;
			current.g <= answer.gn;
			current.top <= '0;
			current.state <= applyState;
		end
		if (reqPop)
			current <= reqTop;
		if (fetchDone)
			answer <= fetchResult;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			finished <= 1'b1; // Idle controller counts as finished
			finalResult <= `BDD_ZERO;
			cfgReadValid <= 1'b0;
		end
		else
		begin
			if (startWrite)
				finished <= 1'b0;
			if (state == seqFinish)
			begin
				finished <= 1'b1;
				finalResult <= resTop; // Last entry left on the result stack
			end
			cfgReadValid <= cfgRead && (cfgAddress == wordResult);
		end
	end

	always_ff @(posedge clk)
	begin
		cfgReadData <= finished ? {{(`CFG_DATA_W - `BDD_INDEX_W){1'b0}}, finalResult} : '1;
	end

endmodule

// File: logic/reduceUnit.sv
`timescale 1ns/1ns

module reduceUnit
	import bddPkg::*;
(
	input logic clk,
	input logic reset,
	input logic reduceStart,
	input bddVarT reduceTop,
	input bddIndexT resTop,
	input bddIndexT resNext,
	output logic resPopTwo,
	output logic resPush,
	output bddIndexT resPushData,
	output logic insertReq,
	output bddIndexT insertE,
	output bddIndexT insertT,
	output bddVarT insertTop,
	input logic insertDone,
	input bddIndexT insertResult,
	output logic reduceDone
);

	typedef enum logic [2:0] {
		rdIdle,
		rdCompare,
		rdRequest,
		rdWait,
		rdPush
	} rdStateT;

	rdStateT state;
	bddIndexT e; // Else result, top of stack
	bddIndexT t; // Then result, one below
	bddVarT top;
	bddIndexT reduced;

	// Both operands leave the stack on the edge that latches them
	assign resPopTwo = reduceStart;
	assign insertReq = (state == rdRequest);
	assign insertE = e;
	assign insertT = t;
	assign insertTop = top;
	assign resPush = (state == rdPush);
	assign resPushData = reduced;
	assign reduceDone = (state == rdPush);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= rdIdle;
		else
		begin
			case (state)
				rdIdle:
				begin
					if (reduceStart)
						state <= rdCompare;
				end
				rdCompare: state <= (e == t) ? rdPush : rdRequest;
				rdRequest: state <= rdWait;
				rdWait:
				begin
					if (insertDone)
						state <= rdPush;
				end
				rdPush: state <= rdIdle;
				default: state <= rdIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reduceStart)
		begin
			e <= resTop;
			t <= resNext;
			top <= reduceTop;
		end
		if (state == rdCompare)
			reduced <= e; // Equal halves need no new node
		if (state == rdWait && insertDone)
			reduced <= insertResult;
	end

endmodule

// File: logic/agentPort.sv
`timescale 1ns/1ns

module agentPort
	import bddPkg::*;
(
	input logic clk,
	input logic reset,
	input logic fetchReq,
	input bddIndexT fetchF,
	input bddIndexT fetchG,
	input logic insertReq,
	input bddIndexT insertE,
	input bddIndexT insertT,
	input bddVarT insertTop,
	output agentRequestT agentReq,
	output logic agentReqValid,
	input logic agentReqReady,
	input agentResultT agentRes,
	input logic agentResValid,
	output logic fetchDone,
	output agentResultT fetchResult,
	output logic insertDone,
	output bddIndexT insertResult
);

	// Held valid until the agent takes it
	always_ff @(posedge clk)
	begin
		if (reset)
			agentReqValid <= 1'b0;
		else if (fetchReq || insertReq)
			agentReqValid <= 1'b1;
		else if (agentReqReady)
			agentReqValid <= 1'b0;
	end

	// One source at a time, and only when nothing is outstanding
	always_ff @(posedge clk)
	begin
		if (fetchReq)
		begin
			agentReq.chan <= fetch;
			agentReq.a <= fetchF;
			agentReq.b <= fetchG;
			agentReq.top <= '0;
		end
		else if (insertReq)
		begin
			agentReq.chan <= findOrInsert;
			agentReq.a <= insertE;
			agentReq.b <= insertT;
			agentReq.top <= insertTop;
		end
	end

	// Responses are always taken and steered by channel
	assign fetchDone = agentResValid && (agentRes.chan == fetch);
	assign fetchResult = agentRes;
	assign insertDone = agentResValid && (agentRes.chan == findOrInsert);
	assign insertResult = agentRes.result;

endmodule

// File: logic/depthController.sv
`timescale 1ns/1ns

`include "bdd_settings.svh"

module depthController
	import bddPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`CFG_ADDR_W-1:0] cfgAddress,
	input logic cfgWrite,
	input logic [`CFG_DATA_W-1:0] cfgWriteData,
	input logic cfgRead,
	output logic [`CFG_DATA_W-1:0] cfgReadData,
	output logic cfgReadValid,
	output agentRequestT agentReq,
	output logic agentReqValid,
	input logic agentReqReady,
	input agentResultT agentRes,
	input logic agentResValid
);

	logic reqPush;
	logic reqPop;
	logic reqEmpty;
	bddRequestT reqPushData;
	bddRequestT reqTop;
	logic seqResPush;
	logic redResPush;
	logic resPush;
	logic resPopTwo;
	bddIndexT seqResData;
	bddIndexT redResData;
	bddIndexT resPushData;
	bddIndexT resTop;
	bddIndexT resNext;
	logic clear;
	logic fetchReq;
	logic fetchDone;
	bddIndexT fetchF;
	bddIndexT fetchG;
	agentResultT fetchResult;
	logic reduceStart;
	logic reduceDone;
	bddVarT reduceTop;
	logic insertReq;
	logic insertDone;
	bddIndexT insertE;
	bddIndexT insertT;
	bddIndexT insertResult;
	bddVarT insertTop;

	// Simple hits and reduced nodes never land in the same cycle
	assign resPush = seqResPush || redResPush;
	assign resPushData = redResPush ? redResData : seqResData;

	requestSequencer requestSequencer_i (
		.resPush(seqResPush),
		.resPushData(seqResData),
		.*
	);

	reduceUnit reduceUnit_i (
		.resPush(redResPush),
		.resPushData(redResData),
		.*
	);

	agentPort agentPort_i (.*);

	bddLifo #(
		.payloadT(bddRequestT),
		.depth(`REQ_STACK_DEPTH)
	) reqStack (
		.clk,
		.reset,
		.clear,
		.push(reqPush),
		.pushData(reqPushData),
		.popOne(reqPop),
		.popTwo(1'b0),
		.top(reqTop),
		.next(),
		.empty(reqEmpty)
	);

	bddLifo #(
		.payloadT(bddIndexT),
		.depth(`RES_STACK_DEPTH)
	) resStack (
		.clk,
		.reset,
		.clear,
		.push(resPush),
		.pushData(resPushData),
		.popOne(1'b0),
		.popTwo(resPopTwo),
		.top(resTop),
		.next(resNext),
		.empty()
	);

endmodule

// File: bench/depthController_assertions.sv
`timescale 1ns/1ns

module depthController_assertions
	import bddPkg::*;
(
	input logic clk,
	input logic reset,
	input agentRequestT agentReq,
	input logic agentReqValid,
	input logic agentReqReady,
	input logic cfgReadValid
);

	// A stalled request must not change or drop
	holdRequest: assert property (@(posedge clk) disable iff (reset)
		agentReqValid && !agentReqReady |=> agentReqValid && $stable(agentReq))
		else $error("agentReq changed while waiting for agentReqReady");

	singleReadPulse: assert property (@(posedge clk) disable iff (reset)
		cfgReadValid |=> !cfgReadValid)
		else $error("cfgReadValid high on two cycles in a row");

endmodule

bind depthController depthController_assertions depthController_assertions_i (
	.clk,
	.reset,
	.agentReq,
	.agentReqValid,
	.agentReqReady,
	.cfgReadValid
);

// File: bench/depthControllerTb.sv
`timescale 1ns/1ns

`include "bdd_settings.svh"

module depthControllerTb
	import bddPkg::*;
;

	typedef struct {
		bddIndexT f;
		bddIndexT g;
		logic mirror; // Agent returns the Then cofactors for both halves
		bddIndexT expected;
	} rowT;

	logic clk;
	logic reset;
	logic [`CFG_ADDR_W-1:0] cfgAddress;
	logic cfgWrite;
	logic [`CFG_DATA_W-1:0] cfgWriteData;
	logic cfgRead;
	logic [`CFG_DATA_W-1:0] cfgReadData;
	logic cfgReadValid;
	agentRequestT agentReq;
	logic agentReqValid;
	logic agentReqReady;
	agentResultT agentRes;
	logic agentResValid;

	logic [31:0] lfsr = 32'hfeacab30;
	logic mirrorMode;
	logic insertSeen; // Any find-or-insert during the current run
	rowT rows[$];
	logic [`CFG_DATA_W-1:0] readValue;

	depthController depthController_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic nextBit();
		logic lsb;
		lsb = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb)
			lfsr = lfsr ^ 32'h80200003;
		return lsb;
	endfunction

	function automatic int randomBits(int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
			value = (value << 1) | nextBit();
		return value;
	endfunction

	function automatic logic isSimple(bddIndexT f, bddIndexT g);
		return f == 0 || g == 0 || f == 1 || g == 1 || f == g;
	endfunction

	function automatic bddIndexT simpleValue(bddIndexT f, bddIndexT g);
		if (f == 0 || g == 0)
			return 0;
		if (f == 1)
			return g;
		return f; // g is one or f equals g
	endfunction

	function automatic bddIndexT insertValue(bddIndexT e, bddIndexT t, bddVarT top);
		logic [31:0] sum;
		sum = 3 * e + 5 * t + top;
		return sum[`BDD_INDEX_W-1:0] | 24'h2;
	endfunction

	function automatic bddIndexT refApply(bddIndexT f, bddIndexT g, logic mirror);
		bddIndexT thenR;
		bddIndexT elseR;
		if (isSimple(f, g))
			return simpleValue(f, g);
		thenR = refApply(f >> 1, g >> 1, mirror);
		elseR = mirror ? thenR : refApply(f >> 2, g >> 2, mirror);
		if (thenR == elseR)
			return thenR;
		return insertValue(elseR, thenR, bddVarT'(f ^ g));
	endfunction

	task automatic failNow(string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got %h, expected %h", name, actual, expected);
			failNow("Value mismatch");
		end
	endtask

	// Random stalls on the request port
	initial
	begin
		forever
		begin
			@(posedge clk);
			#1 agentReqReady = nextBit();
		end
	end

	// Agent model with one transaction at a time and a random answer delay
	initial
	begin
		agentRequestT req;
		agentResultT answer;
		int delay;
		forever
		begin
			@(negedge clk);
			if (!reset && agentReqValid && agentReqReady)
			begin
				req = agentReq;
				answer = '0;
				answer.chan = req.chan;
				if (req.chan == findOrInsert)
				begin
					insertSeen = 1'b1;
					answer.result = insertValue(req.a, req.b, req.top);
				end
				else if (isSimple(req.a, req.b))
				begin
					answer.simpleHit = 1'b1;
					answer.result = simpleValue(req.a, req.b);
				end
				else
				begin
					answer.fn = req.a >> 1;
					answer.gn = req.b >> 1;
					answer.fnv = mirrorMode ? req.a >> 1 : req.a >> 2;
					answer.gnv = mirrorMode ? req.b >> 1 : req.b >> 2;
					answer.top = bddVarT'(req.a ^ req.b);
				end
				@(posedge clk); // Transfer edge
				delay = randomBits(2);
				repeat (delay) @(posedge clk);
				#1;
				agentRes = answer;
				agentResValid = 1'b1;
				@(posedge clk);
				#1 agentResValid = 1'b0;
			end
		end
	end

	// Called one step after a rising edge
	task automatic writeWord(logic [`CFG_ADDR_W-1:0] word, logic [`CFG_DATA_W-1:0] data);
		cfgAddress = word;
		cfgWriteData = data;
		cfgWrite = 1'b1;
		@(posedge clk);
		#1 cfgWrite = 1'b0;
	endtask

	task automatic readWord(output logic [`CFG_DATA_W-1:0] data);
		int cycles;
		@(posedge clk); // Gap keeps read pulses apart
		#1;
		cfgAddress = `CFG_WORD_RESULT;
		cfgRead = 1'b1;
		@(posedge clk);
		#1 cfgRead = 1'b0;
		cycles = 0;
		while (!cfgReadValid)
		begin
			if (cycles == 20)
				failNow("No cfgReadValid after a read of the result word");
			@(posedge clk);
			#1 cycles++;
		end
		data = cfgReadData;
	endtask

	task automatic waitResult(output logic [`CFG_DATA_W-1:0] data);
		int polls;
		polls = 0;
		readWord(data);
		while (data == '1)
		begin
			if (polls == 5000)
				failNow("Controller did not finish in time");
			readWord(data);
			polls++;
		end
	endtask

	function automatic void addRow(bddIndexT f, bddIndexT g, logic mirror, bddIndexT expected);
		rows.push_back('{f, g, mirror, expected});
	endfunction

	initial
	begin
		reset = 1'b1;
		cfgAddress = '0;
		cfgWrite = 1'b0;
		cfgWriteData = '0;
		cfgRead = 1'b0;
		agentReqReady = 1'b0;
		agentRes = '0;
		agentResValid = 1'b0;
		mirrorMode = 1'b0;
		insertSeen = 1'b0;

		addRow(24'd5, 24'd0, 1'b0, 24'd0); // Terminal operands
		addRow(24'd1, 24'd77, 1'b0, 24'd77);
		addRow(24'd300, 24'd1, 1'b0, 24'd300);
		addRow(24'd42, 24'd42, 1'b0, 24'd42);
		addRow(24'd6, 24'd9, 1'b0, refApply(24'd6, 24'd9, 1'b0));
		addRow(24'd100, 24'd200, 1'b0, refApply(24'd100, 24'd200, 1'b0));
		addRow(24'd1023, 24'd512, 1'b0, refApply(24'd1023, 24'd512, 1'b0));
		addRow(24'd700, 24'd3, 1'b0, refApply(24'd700, 24'd3, 1'b0));
		addRow(24'd37, 24'd999, 1'b0, refApply(24'd37, 24'd999, 1'b0));
		addRow(24'd6, 24'd9, 1'b1, refApply(24'd6, 24'd9, 1'b1)); // Equal halves all the way
		addRow(24'd850, 24'd333, 1'b1, refApply(24'd850, 24'd333, 1'b1));

		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		foreach (rows[i])
		begin
			mirrorMode = rows[i].mirror;
			insertSeen = 1'b0;
			writeWord(`CFG_WORD_F, {8'h00, rows[i].f});
			writeWord(`CFG_WORD_G, {8'h00, rows[i].g});
			writeWord(`CFG_WORD_START, 32'h1);
			readWord(readValue);
			checkValue("cfgReadData while busy", readValue, 32'hffffffff);
			waitResult(readValue);
			checkValue("cfgReadData", readValue, {8'h00, rows[i].expected});
			if (rows[i].mirror)
				checkValue("findOrInsert requests", {31'd0, insertSeen}, 32'd0);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// File: tb.f
+incdir+logic
logic/bddPkg.sv
logic/bddLifo.sv
logic/requestSequencer.sv
logic/reduceUnit.sv
logic/agentPort.sv
logic/depthController.sv
bench/depthController_assertions.sv
bench/depthControllerTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= depthControllerTb
FILELIST ?= tb.f
OBJDIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^\*\* PASS \*\*" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
